/* Makefile */
TOP = buzzer_music_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "test passed"

clean:
	rm -rf obj_dir

/* bench/buzzer_music_tb.sv */
module buzzer_music_tb import buzzer_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [3:0]  row;
    logic [3:0]  col;
    logic        beep;
    logic        playing;

    logic [11:0] song_mem [48];
    int          cyc = 0;
    int          limit_cycles = 0;
    int          exp_edges [$];
    int          act_edges [$];
    int          exp_len;
    int          first_len;
    logic        key_down;
    logic [1:0]  key_row;
    logic [1:0]  key_col;
    string       test_name;
    int          test_errs;
    int          n_ok;
    int          n_fail;

    buzzer_music #(
        .debounce_cycles(4),
        .scan_cycles    (8),
        .tempo_reset    (16'd20)
    ) buzzer_music_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr),
        .row    (row),
        .col    (col),
        .beep   (beep)
    );

    // Player state is only visible inside the DUT
    assign playing = buzzer_music_i.stat.playing;

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // Pressed key pulls its column low while its row is driven
    always_comb begin
        col = 4'hf;
        if (key_down && !row[key_row]) col[key_col] = 1'b0;
    end

    ////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
        test_errs++;
    endtask

    task automatic report_failure(input string what);
        $display("[ERROR] %s: %s", test_name, what);
        test_errs++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            n_ok++;
            $display("ok    %s", test_name);
        end else begin
            n_fail++;
            $display("FAIL  %s (%0d errors)", test_name, test_errs);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // APB and keypad drivers
    ////////////////////////////////////////////////////////////

    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        if (pready !== 1'b1) report_failure("pready low in the access phase");
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, wdata, rd, err);
        if (err !== 1'b0) report_failure("pslverr raised on a mapped write");
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] rd);
        logic err;
        apb_access(1'b0, addr, 32'd0, rd, err);
        if (err !== 1'b0) report_failure("pslverr raised on a mapped read");
    endtask

    task automatic check_reg(input logic [3:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] rd;
        apb_read(addr, rd);
        if (rd !== exp) report_mismatch(what, exp, rd);
    endtask

    task automatic press_key(input int k);
        @(posedge clk);
        #1;
        key_row  = 2'(k / 4);
        key_col  = 2'(k % 4);
        key_down = 1'b1;
    endtask

    task automatic release_key();
        @(posedge clk);
        #1;
        key_down = 1'b0;
        // Scanner has to see all columns high before the next press
        repeat (12) @(posedge clk);
    endtask

    task automatic poll_key(output logic seen, output logic [31:0] rd);
        int tries;
        seen  = 1'b0;
        tries = 0;
        rd    = 32'd0;
        while (!seen && tries < 60) begin
            apb_read(reg_lastkey, rd);
            seen = rd[8];
            tries++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Note model and beep capture
    ////////////////////////////////////////////////////////////

    // Beep edge times counted in cycles from the rise of playing
    task automatic build_model(input int song, input int tempo);
        logic [11:0] entry;
        int          idx;
        int          off;
        int          n;
        int          hp;
        int          k;
        logic        ended;
        exp_edges.delete();
        off       = 0;
        idx       = 0;
        ended     = 1'b0;
        first_len = 0;
        while (!ended && idx < song_len) begin
            entry = song_mem[song * song_len + idx];
            if (entry[11:4] == 8'hff) begin
                // End marker still spends fetch and decode
                off   = off + 2;
                ended = 1'b1;
            end else begin
                n = ((entry[3:0] == 4'd0) ? 1 : int'(entry[3:0])) * tempo;
                if (entry[7:4] != 4'd0) begin
                    hp = int'(pitch_half_period[int'(entry[7:4]) - 1]) >> entry[11:8];
                    k  = 1;
                    while (k * hp <= n) begin
                        exp_edges.push_back(off + 2 + k * hp);
                        k++;
                    end
                    // Odd toggle count leaves beep high until the tone is cleared
                    if ((n / hp) % 2 == 1) exp_edges.push_back(off + 3 + n);
                end
                off = off + 2 + n;
                idx++;
                if (idx == 1) first_len = off + 1;
            end
        end
        exp_len = off + 1;
    endtask

    task automatic capture_play(input int max_cycles, output logic got_rise, output int len);
        int   spin;
        int   rise_cyc;
        logic prev;
        act_edges.delete();
        got_rise = 1'b0;
        len      = 0;
        spin     = 0;
        @(negedge clk);
        while (!playing && spin < 300) begin
            @(negedge clk);
            spin++;
        end
        if (playing) begin
            got_rise = 1'b1;
            rise_cyc = cyc;
            prev     = beep;
            while (playing && len < max_cycles) begin
                len++;
                @(negedge clk);
                if (beep !== prev) begin
                    act_edges.push_back(cyc - rise_cyc);
                    prev = beep;
                end
            end
        end
    endtask

    task automatic compare_edges(input int limit);
        int   n;
        int   i;
        logic bad;
        n = 0;
        foreach (exp_edges[j]) begin
            if (exp_edges[j] <= limit) n++;
        end
        if (act_edges.size() != n) report_mismatch("beep edge count", n, act_edges.size());
        i   = 0;
        bad = 1'b0;
        while (!bad && i < n && i < act_edges.size()) begin
            if (act_edges[i] != exp_edges[i]) begin
                report_mismatch("beep edge cycle", exp_edges[i], act_edges[i]);
                bad = 1'b1;
            end
            i++;
        end
    endtask

    task automatic play_and_check(input int song, input int tempo);
        int          len;
        logic        ok;
        logic [31:0] rd;
        build_model(song, tempo);
        apb_write(reg_tempo, tempo);
        apb_write(reg_ctrl, {27'd0, 1'b1, 2'(song), 2'b01});
        capture_play(exp_len + 20, ok, len);
        if (!ok) begin
            report_failure("playing never rose after start");
        end else begin
            compare_edges(exp_len);
            if (len != exp_len) report_mismatch("playing length", exp_len, len);
        end
        apb_read(reg_status, rd);
        if (rd[1] !== 1'b1) report_failure("status done not set at song end");
        apb_write(reg_status, 32'h2);
        apb_read(reg_status, rd);
        if (rd[1:0] !== 2'b00) report_mismatch("status after done clear", 0, {30'd0, rd[1:0]});
    endtask

    ////////////////////////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////////////////////////

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Run stopped after %0d cycles without finishing", limit_cycles);
        $display("test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    initial begin
        int          i;
        int          j;
        int          tmp;
        int          song;
        int          tempo;
        int          k;
        int          len;
        int          drop;
        int          total;
        int          order [3];
        logic        ok;
        logic        err;
        logic        quiet;
        logic [31:0] rd;
        logic [31:0] wd;
        logic [3:0]  addr;

        void'($urandom(32'hccc48949));
        clk      = 1'b0;
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = 4'd0;
        pwdata   = 32'd0;
        key_down = 1'b0;
        key_row  = 2'd0;
        key_col  = 2'd0;
        n_ok     = 0;
        n_fail   = 0;
        start_test("setup");
        $readmemh("design/songs.mem", song_mem);
        total = 0;
        for (i = 0; i < 3; i++) begin
            build_model(i, 40);
            total = total + exp_len;
        end
        limit_cycles = 2 * total + 10000;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test("register_access");
        if (row !== 4'b1110) report_mismatch("row after reset", 32'he, {28'd0, row});
        if (beep !== 1'b0) report_failure("beep high after reset");
        check_reg(reg_ctrl, 32'h10, "ctrl reset value");
        check_reg(reg_tempo, 32'd20, "tempo reset value");
        check_reg(reg_status, 32'h0, "status reset value");
        check_reg(reg_lastkey, 32'h0, "lastkey reset value");
        for (i = 0; i < 4; i++) begin
            // Stop is always set so a random start never plays
            wd    = $urandom;
            wd[1] = 1'b1;
            apb_write(reg_ctrl, wd);
            check_reg(reg_ctrl, {27'd0, wd[4], wd[3:2], 2'b00}, "ctrl readback");
            wd = $urandom;
            apb_write(reg_tempo, wd);
            check_reg(reg_tempo, {16'd0, wd[15:0]}, "tempo readback");
            addr = 4'($urandom_range(0, 15));
            if (addr[1:0] == 2'b00) addr[0] = 1'b1;
            apb_access(1'b1, addr, $urandom, rd, err);
            if (err !== 1'b1) report_failure("no pslverr on an unmapped write");
            apb_access(1'b0, addr, 32'd0, rd, err);
            if (err !== 1'b1) report_failure("no pslverr on an unmapped read");
            if (rd !== 32'd0) report_mismatch("unmapped read data", 0, rd);
            check_reg(reg_tempo, {16'd0, wd[15:0]}, "tempo after unmapped write");
        end
        apb_write(reg_ctrl, 32'h12);
        apb_write(reg_tempo, 32'd20);
        finish_test();

        start_test("apb_playback");
        play_and_check($urandom_range(0, 2), $urandom_range(8, 40));
        finish_test();

        start_test("stop_and_restart");
        song  = $urandom_range(0, 2);
        tempo = $urandom_range(8, 40);
        build_model(song, tempo);
        apb_write(reg_tempo, tempo);
        apb_write(reg_ctrl, {27'd0, 1'b1, 2'(song), 2'b01});
        capture_play(exp_len / 2, ok, len);
        if (!ok) report_failure("playing never rose after start");
        apb_write(reg_ctrl, 32'h12);
        drop = 0;
        while (playing && drop < 10) begin
            @(negedge clk);
            drop++;
        end
        if (drop > 2) report_failure("playing did not drop right after stop");
        @(negedge clk);
        quiet = 1'b1;
        repeat (40) begin
            if (beep !== 1'b0) quiet = 1'b0;
            @(negedge clk);
        end
        if (!quiet) report_failure("beep not silent after stop");
        apb_read(reg_status, rd);
        if (rd[1:0] !== 2'b00) report_mismatch("status after stop", 0, {30'd0, rd[1:0]});
        play_and_check(song, tempo);
        finish_test();

        start_test("keypad_control");
        k = 2 + $urandom_range(0, 13);
        press_key(k);
        poll_key(ok, rd);
        if (!ok) begin
            report_failure("no key event for a held key");
        end else if (rd[3:0] != k[3:0]) begin
            report_mismatch("lastkey code", k, {28'd0, rd[3:0]});
        end
        release_key();
        check_reg(reg_lastkey, {23'd0, 1'b0, 4'd0, 4'(k)}, "lastkey after read");
        song  = $urandom_range(0, 2);
        tempo = $urandom_range(8, 40);
        build_model(song, tempo);
        apb_write(reg_tempo, tempo);
        apb_write(reg_ctrl, {27'd0, 1'b1, 2'(song), 2'b00});
        press_key(0);
        capture_play(first_len, ok, len);
        if (!ok) begin
            report_failure("key 0 did not start playback");
        end else begin
            compare_edges(first_len);
        end
        release_key();
        press_key(1);
        drop = 0;
        while (playing && drop < 200) begin
            @(negedge clk);
            drop++;
        end
        if (playing) report_failure("key 1 did not stop playback");
        // A song that ran to its end would have set done
        apb_read(reg_status, rd);
        if (rd[1] !== 1'b0) report_failure("song ended on its own instead of stopping on key 1");
        release_key();
        // Keys are still logged but no longer control the player
        apb_write(reg_ctrl, 32'h0);
        press_key(0);
        poll_key(ok, rd);
        if (!ok) report_failure("no key event with key_enable clear");
        repeat (4) @(posedge clk);
        if (playing) report_failure("key 0 started playback with key_enable clear");
        release_key();
        apb_write(reg_ctrl, 32'h10);
        apb_write(reg_status, 32'h2);
        finish_test();

        start_test("song_select");
        for (i = 0; i < 3; i++) order[i] = i;
        for (i = 2; i > 0; i--) begin
            j        = $urandom_range(0, i);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < 3; i++) play_and_check(order[i], $urandom_range(8, 40));
        finish_test();

        $display("summary: %0d tests ok, %0d tests failing", n_ok, n_fail);
        if (n_fail == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* design/buzzer_music.sv */
module buzzer_music import buzzer_pkg::*; #(
    parameter int          debounce_cycles = 200000,
    parameter int          scan_cycles     = 50000,
    parameter logic [15:0] tempo_reset     = 16'd60000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [3:0]  row,
    input  logic [3:0]  col,
    output logic        beep
);

    logic         key_valid;
    logic [3:0]   key_code;
    player_cmd_t  cmd;
    player_stat_t stat;
    logic [5:0]   rom_addr;
    note_entry_t  rom_data;
    tone_cfg_t    tone;

    ////////////////////////////////////////////////////////////
    // Keypad and register front end
    ////////////////////////////////////////////////////////////

    keypad_scan #(
        .debounce_cycles(debounce_cycles),
        .scan_cycles    (scan_cycles)
    ) keypad_scan_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .col      (col),
        .row      (row),
        .key_valid(key_valid),
        .key_code (key_code)
    );

    music_regs #(
        .tempo_reset(tempo_reset)
    ) music_regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .key_valid(key_valid),
        .key_code (key_code),
        .cmd      (cmd),
        .stat     (stat)
    );

    ////////////////////////////////////////////////////////////
    // Playback path
    ////////////////////////////////////////////////////////////

    note_player note_player_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd     (cmd),
        .stat    (stat),
        .rom_addr(rom_addr),
        .rom_data(rom_data),
        .tone    (tone)
    );

    song_rom song_rom_i (
        .clk (clk),
        .addr(rom_addr),
        .data(rom_data)
    );

    tone_gen tone_gen_i (
        .clk  (clk),
        .rst_n(rst_n),
        .tone (tone),
        .beep (beep)
    );

endmodule

/* design/buzzer_pkg.sv */
package buzzer_pkg;

    ////////////////////////////////////////////////////////////
    // Song entry and inter-block structs
    ////////////////////////////////////////////////////////////

    // Octave in the high nibble, pitch 1..12 in the low nibble
    typedef struct packed {
        logic [7:0] note_code;
        logic [3:0] beats;
    } note_entry_t;

    typedef struct packed {
        logic        start;
        logic        stop;
        logic [1:0]  song;
        logic [15:0] tempo;
    } player_cmd_t;

    typedef struct packed {
        logic       playing;
        logic       done;
        logic [3:0] index;
    } player_stat_t;

    typedef struct packed {
        logic        sound;
        logic [15:0] half_period;
    } tone_cfg_t;

    typedef enum logic [2:0] {
        idle,
        fetch,
        decode,
        sound,
        finish
    } play_state_t;

    typedef enum logic [3:0] {
        key_start = 4'd0,
        key_stop  = 4'd1,
        key_other = 4'd2
    } key_cmd_t;

    ////////////////////////////////////////////////////////////
    // Register map and note constants
    ////////////////////////////////////////////////////////////

    localparam logic [3:0] reg_ctrl    = 4'h0;
    localparam logic [3:0] reg_tempo   = 4'h4;
    localparam logic [3:0] reg_status  = 4'h8;
    localparam logic [3:0] reg_lastkey = 4'hc;

    localparam int song_len = 16;

    // Octave 0 half-periods, equal-tempered steps
    localparam logic [15:0] pitch_half_period [12] = '{
        16'd240, 16'd227, 16'd214, 16'd202, 16'd190, 16'd180,
        16'd170, 16'd160, 16'd151, 16'd143, 16'd135, 16'd127
    };

endpackage

/* design/keypad_scan.sv */
module keypad_scan #(
    parameter int debounce_cycles = 200000,
    parameter int scan_cycles     = 50000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] col,
    output logic [3:0] row,
    output logic       key_valid,
    output logic [3:0] key_code
);

    localparam int scan_w = $clog2(scan_cycles + 1);
    localparam int db_w   = $clog2(debounce_cycles + 1);

    logic [3:0]        col_meta;
    logic [3:0]        col_s;
    logic [3:0]        col_last;
    logic              pressed;
    logic [1:0]        row_idx;
    logic [scan_w-1:0] scan_cnt;
    logic [db_w-1:0]   db_cnt;
    logic              locked;
    logic [1:0]        col_num;

    // Two-stage synchronizer on the column pins
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_meta <= 4'hf;
            col_s    <= 4'hf;
            col_last <= 4'hf;
        end else begin
            col_meta <= col;
            col_s    <= col_meta;
            col_last <= col_s;
        end
    end

    assign pressed = (col_s != 4'hf);
    assign row     = ~(4'b0001 << row_idx);

    // Lowest active column wins
    always_comb begin
        col_num = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (!col_s[i]) col_num = 2'(i);
        end
    end

    // Row scan, frozen while a column is held low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_idx  <= 2'd0;
            scan_cnt <= '0;
        end else if (!pressed) begin
            if (scan_cnt == scan_w'(scan_cycles - 1)) begin
                scan_cnt <= '0;
                row_idx  <= row_idx + 2'd1;
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
        end
    end

    // Debounce and one event per press
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            db_cnt    <= '0;
            locked    <= 1'b0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            if (!pressed) begin
                db_cnt <= '0;
                locked <= 1'b0;
            end else if (!locked) begin
                if (col_s != col_last) begin
                    db_cnt <= '0;
                end else if (db_cnt == db_w'(debounce_cycles - 1)) begin
                    db_cnt    <= '0;
                    locked    <= 1'b1;
                    key_valid <= 1'b1;
                end else begin
                    db_cnt <= db_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pressed && !locked && col_s == col_last) key_code <= {row_idx, col_num};
    end

endmodule

/* design/music_regs.sv */
module music_regs import buzzer_pkg::*; #(
    parameter logic [15:0] tempo_reset = 16'd60000
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  logic [3:0]   paddr,
    input  logic [31:0]  pwdata,
    output logic [31:0]  prdata,
    output logic         pready,
    output logic         pslverr,
    input  logic         key_valid,
    input  logic [3:0]   key_code,
    output player_cmd_t  cmd,
    input  player_stat_t stat
);

    logic        access;
    logic        wr_en;
    logic        rd_en;
    logic        mapped;
    logic        key_en_q;
    logic [1:0]  song_q;
    logic [15:0] tempo_q;
    logic        done_q;
    logic [3:0]  lastkey_q;
    logic        lastkey_vld_q;
    logic        start_q;
    logic        stop_q;
    key_cmd_t    key_kind;

    ////////////////////////////////////////////////////////////
    // APB decode
    ////////////////////////////////////////////////////////////

    assign access  = psel && penable;
    assign mapped  = (paddr == reg_ctrl) || (paddr == reg_tempo) ||
                     (paddr == reg_status) || (paddr == reg_lastkey);
    assign wr_en   = access && pwrite && mapped;
    assign rd_en   = access && !pwrite && mapped;
    assign pready  = 1'b1;
    assign pslverr = access && !mapped;

    always_comb begin
        case (paddr)
            reg_ctrl:    prdata = {27'd0, key_en_q, song_q, 2'b00};
            reg_tempo:   prdata = {16'd0, tempo_q};
            reg_status:  prdata = {24'd0, stat.index, 2'b00, done_q, stat.playing};
            reg_lastkey: prdata = {23'd0, lastkey_vld_q, 4'd0, lastkey_q};
            default:     prdata = 32'd0;
        endcase
    end

    always_comb begin
        case (key_code)
            4'd0:    key_kind = key_start;
            4'd1:    key_kind = key_stop;
            default: key_kind = key_other;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Register state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_en_q      <= 1'b1;
            song_q        <= 2'd0;
            tempo_q       <= tempo_reset;
            done_q        <= 1'b0;
            lastkey_q     <= 4'd0;
            lastkey_vld_q <= 1'b0;
            start_q       <= 1'b0;
            stop_q        <= 1'b0;
        end else begin
            // APB and key commands merge into one pulse each
            start_q <= (wr_en && paddr == reg_ctrl && pwdata[0]) ||
                       (key_en_q && key_valid && key_kind == key_start);
            stop_q  <= (wr_en && paddr == reg_ctrl && pwdata[1]) ||
                       (key_en_q && key_valid && key_kind == key_stop);
            if (wr_en && paddr == reg_ctrl) begin
                song_q   <= pwdata[3:2];
                key_en_q <= pwdata[4];
            end
            if (wr_en && paddr == reg_tempo) tempo_q <= pwdata[15:0];
            if (stat.done) begin
                done_q <= 1'b1;
            end else if (wr_en && paddr == reg_status && pwdata[1]) begin
                done_q <= 1'b0;
            end
            // New key event wins over the clear-on-read
            if (key_valid) begin
                lastkey_q     <= key_code;
                lastkey_vld_q <= 1'b1;
            end else if (rd_en && paddr == reg_lastkey) begin
                lastkey_vld_q <= 1'b0;
            end
        end
    end

    assign cmd = '{start: start_q, stop: stop_q, song: song_q, tempo: tempo_q};

endmodule

/* design/note_player.sv */
module note_player import buzzer_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  player_cmd_t  cmd,
    output player_stat_t stat,
    output logic [5:0]   rom_addr,
    input  note_entry_t  rom_data,
    output tone_cfg_t    tone
);

    play_state_t state;
    logic [1:0]  song_q;
    logic [3:0]  index;
    logic [15:0] tempo_q;
    logic [15:0] cyc_cnt;
    logic [3:0]  beats_left;
    logic        mute_q;
    logic [15:0] half_period_q;
    logic [3:0]  pitch;
    logic [3:0]  octave;
    logic [3:0]  pitch_idx;
    logic        is_end;
    logic        is_rest;
    logic        beat_last;
    logic        note_last;

    ////////////////////////////////////////////////////////////
    // Entry decode
    ////////////////////////////////////////////////////////////

    assign pitch     = rom_data.note_code[3:0];
    assign octave    = rom_data.note_code[7:4];
    assign is_end    = (rom_data.note_code == 8'hff);
    // Code 0 is a rest, out-of-range pitches are muted too
    assign is_rest   = (pitch == 4'd0) || (pitch > 4'd12);
    assign pitch_idx = is_rest ? 4'd0 : pitch - 4'd1;

    assign beat_last = (cyc_cnt == tempo_q - 16'd1);
    assign note_last = beat_last && (beats_left == 4'd1);

    assign rom_addr  = {song_q, index};

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= idle;
            index   <= 4'd0;
            song_q  <= 2'd0;
            tempo_q <= 16'd1;
        end else if (cmd.stop) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (cmd.start) begin
                        state   <= fetch;
                        index   <= 4'd0;
                        song_q  <= (cmd.song == 2'd3) ? 2'd0 : cmd.song;
                        tempo_q <= (cmd.tempo == 16'd0) ? 16'd1 : cmd.tempo;
                    end
                end
                fetch:  state <= decode;
                decode: state <= is_end ? finish : sound;
                sound: begin
                    if (note_last) begin
                        if (index == 4'(song_len - 1)) begin
                            state <= finish;
                        end else begin
                            index <= index + 4'd1;
                            state <= fetch;
                        end
                    end
                end
                finish:  state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // Beat timer and latched pitch
    always_ff @(posedge clk) begin
        if (state == decode) begin
            half_period_q <= pitch_half_period[pitch_idx] >> octave;
            mute_q        <= is_rest;
            beats_left    <= (rom_data.beats == 4'd0) ? 4'd1 : rom_data.beats;
            cyc_cnt       <= 16'd0;
        end else if (state == sound) begin
            if (beat_last) begin
                cyc_cnt    <= 16'd0;
                beats_left <= beats_left - 4'd1;
            end else begin
                cyc_cnt <= cyc_cnt + 16'd1;
            end
        end
    end

    always_comb begin
        stat.playing     = (state != idle);
        stat.done        = (state == finish);
        stat.index       = index;
        tone.sound       = (state == sound) && !mute_q;
        tone.half_period = half_period_q;
    end

endmodule

/* design/song_rom.sv */
module song_rom import buzzer_pkg::*; (
    input  logic        clk,
    input  logic [5:0]  addr,
    output note_entry_t data
);

    localparam int depth = 3 * song_len;

    // Three songs back to back, 16 entries each
    logic [11:0] mem [depth];

    initial begin
        $readmemh("design/songs.mem", mem);
    end

    // Registered read, data one cycle after addr
    always_ff @(posedge clk) begin
        data <= note_entry_t'(mem[addr]);
    end

endmodule

/* design/songs.mem */
// Each line holds one entry with the note code in the first two hex digits and the beats last
// Songs 0, 1 and 2 take 16 lines each and note code ff ends a song
314
332
353
002
360
384
2c3
ff0
ff0
ff0
ff0
ff0
ff0
ff0
ff0
ff0
242
263
281
001
2a2
3c3
312
334
002
354
ff0
ff0
ff0
ff0
ff0
ff0
312
322
332
342
354
362
372
384
392
3a2
3b2
3c4
002
2c2
3c1
314

/* design/tone_gen.sv */
module tone_gen import buzzer_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  tone_cfg_t tone,
    output logic      beep
);

    logic [15:0] half_cnt;
    logic        half_last;

    assign half_last = (half_cnt == tone.half_period - 16'd1);

    ////////////////////////////////////////////////////////////
    // Square wave, starts low for one half-period
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            half_cnt <= 16'd0;
            beep     <= 1'b0;
        end else if (!tone.sound) begin
            // Held clear while silent so each note restarts cleanly
            half_cnt <= 16'd0;
            beep     <= 1'b0;
        end else if (half_last) begin
            half_cnt <= 16'd0;
            beep     <= ~beep;
        end else begin
            half_cnt <= half_cnt + 16'd1;
        end
    end

endmodule

/* filelist.f */
design/buzzer_pkg.sv
design/keypad_scan.sv
design/music_regs.sv
design/song_rom.sv
design/note_player.sv
design/tone_gen.sv
design/buzzer_music.sv
bench/buzzer_music_tb.sv
